//--- source/icache_settings.svh
// Instruction cache geometry and the address fields that select bank, set and tag
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ====================
// Cache geometry
// ====================

// Each of the two banks is set associative with this many ways
`define ICACHE_WAYS 4

// Sets per bank, so each bank holds ICACHE_SETS times ICACHE_WAYS lines
`define ICACHE_SETS 16

// A line is eight 32-bit words, 32 bytes
`define ICACHE_LINE_WORDS 8

// ====================
// Address fields
// ====================

// Set index bits, shared by both banks
`define ICACHE_INDEX_LO 6
`define ICACHE_INDEX_HI 9
// Bit 5 picks the bank, clear means the even bank
`define ICACHE_BANK_BIT 5
// Everything from here up to bit 31 is the tag
`define ICACHE_TAG_LO 10

`endif

//--- source/icache_pkg.sv
// Shared types of the instruction cache: widths, port structs and the refill states
`include "icache_settings.svh"

package icache_pkg;

	// Widths that carry a meaning
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [31-`ICACHE_TAG_LO:0] tag_t;
	typedef logic [`ICACHE_INDEX_HI-`ICACHE_INDEX_LO:0] set_index_t;
	typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
	typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_t;
	typedef logic [32*`ICACHE_LINE_WORDS-1:0] line_t;
	// Two consecutive lines, the line holding ip sits in the low half
	typedef logic [64*`ICACHE_LINE_WORDS-1:0] window_t;

	// ====================
	// Port structs
	// ====================

	typedef struct packed {
		logic valid;
		addr_t ip;
	} fetch_req_t;

	typedef struct packed {
		logic valid;
		logic hit;
		addr_t ip;
		window_t window;
	} fetch_rsp_t;

	typedef struct packed {
		logic psel;
		logic penable;
		addr_t paddr;
		logic pwrite;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// One refill word on its way into a bank, commit marks the last beat of the line
	typedef struct packed {
		logic we_even;
		logic we_odd;
		set_index_t index;
		way_t way;
		beat_t beat;
		word_t word;
		tag_t tag;
		logic commit;
	} bank_wr_t;

	// Lines missing from a lookup, given as aligned line addresses
	typedef struct packed {
		logic valid;
		logic need_even;
		logic need_odd;
		addr_t even_addr;
		addr_t odd_addr;
	} miss_t;

	typedef enum logic [2:0] {
		st_idle,
		st_setup,
		st_access,
		st_commit,
		st_error
	} refill_state_t;

endpackage

//--- source/icache_tag_bank.sv
// Tag and valid storage of one cache bank with a registered compare over all ways
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tag_bank import icache_pkg::*; (
	input logic clk,
	input logic reset,
	input set_index_t rd_index,
	input tag_t rd_tag,
	input bank_wr_t wr,
	input logic bank_sel,
	input logic invalidate_all,
	output logic hit,
	output way_t hit_way
);

	// Tags are plain registers, one per set and way
	tag_t tags [`ICACHE_SETS][`ICACHE_WAYS];
	logic [`ICACHE_WAYS-1:0] valid [`ICACHE_SETS];

	logic we;
	logic [`ICACHE_WAYS-1:0] match;
	way_t match_way;

	// The odd bank listens to the odd write enable, the even bank to the even one
	always_comb we = bank_sel ? wr.we_odd : wr.we_even;

	// ====================
	// Compare
	// ====================

	// Every way of the addressed set is checked in parallel
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			match[w] = valid[rd_index][w] && (tags[rd_index][w] == rd_tag);
		end
	end

	// A refill never puts the same line in two ways, so at most one bit is set
	always_comb begin
		match_way = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (match[w]) begin
				match_way = way_t'(w);
			end
		end
	end

	// The compare result lines up with lookup stage 1
	always_ff @(posedge clk) begin
		if (reset) begin
			hit <= 1'b0;
			hit_way <= '0;
		end else begin
			hit <= |match;
			hit_way <= match_way;
		end
	end

	// ====================
	// Update
	// ====================

	// The tag is written only with the last word of the line
	always_ff @(posedge clk) begin
		if (we && wr.commit) begin
			tags[wr.index][wr.way] <= wr.tag;
		end
	end

	// Invalidate wins over a commit on the same edge
	always_ff @(posedge clk) begin
		if (reset || invalidate_all) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				valid[s] <= '0;
			end
		end else if (we && wr.commit) begin
			valid[wr.index][wr.way] <= 1'b1;
		end
	end

endmodule

//--- source/icache_data_bank.sv
// Line data array of one cache bank with word writes and a full-line read
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_data_bank import icache_pkg::*; (
	input logic clk,
	input set_index_t rd_index,
	input way_t rd_way,
	input bank_wr_t wr,
	input logic bank_sel,
	output line_t rd_line
);

	// 16 sets by 4 ways by 8 words, 64 lines in all
	word_t mem [`ICACHE_SETS][`ICACHE_WAYS][`ICACHE_LINE_WORDS];

	// Read index held for the cycle in which the hit way becomes known
	set_index_t index_q;
	logic we;

	always_comb we = bank_sel ? wr.we_odd : wr.we_even;

	// Refill writes one word per beat into the victim way
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr.index][wr.way][wr.beat] <= wr.word;
		end
	end

	// The index is captured together with lookup stage 1
	always_ff @(posedge clk) begin
		index_q <= rd_index;
	end

	// ====================
	// Line read
	// ====================

	// The tag compare picks the way one cycle after the index
	// Word 0 lands in the lowest 32 bits of the line
	always_comb begin
		for (int b = 0; b < `ICACHE_LINE_WORDS; b++) begin
			rd_line[32*b +: 32] = mem[index_q][rd_way][b];
		end
	end

endmodule

//--- source/icache_lookup.sv
// Two-stage lookup pipeline that maps a fetch onto both banks and builds the window
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_lookup import icache_pkg::*; (
	input logic clk,
	input logic reset,
	input fetch_req_t fetch_req,
	input logic fetch_ready,
	output fetch_rsp_t fetch_rsp,
	output miss_t miss,
	output set_index_t even_index,
	output set_index_t odd_index,
	output tag_t even_tag,
	output tag_t odd_tag,
	input logic even_hit,
	input logic odd_hit,
	output way_t even_way,
	output way_t odd_way,
	input way_t even_hit_way,
	input way_t odd_hit_way,
	input line_t even_line,
	input line_t odd_line
);

	// Address bits from the set index upward name a pair of lines
	logic [31-`ICACHE_INDEX_LO:0] req_pair;
	logic [31-`ICACHE_INDEX_LO:0] req_even_pair;
	logic [31-`ICACHE_INDEX_LO:0] s2_even_pair;

	logic accept;

	logic s1_valid;
	addr_t s1_ip;

	logic s2_valid;
	addr_t s2_ip;
	logic s2_even_hit;
	logic s2_odd_hit;
	line_t s2_even_line;
	line_t s2_odd_line;
	logic s2_hit;

	always_comb accept = fetch_req.valid && fetch_ready;

	// ====================
	// Bank mapping
	// ====================

	// The odd line always shares the pair of ip
	// When ip is in an odd line the next line is even and sits in the following pair
	// so its index is one higher and the tag carries on a wrap
	always_comb begin
		req_pair = fetch_req.ip[31:`ICACHE_INDEX_LO];
		req_even_pair = req_pair + fetch_req.ip[`ICACHE_BANK_BIT];
		odd_index = req_pair[`ICACHE_INDEX_HI-`ICACHE_INDEX_LO:0];
		odd_tag = req_pair[31-`ICACHE_INDEX_LO:`ICACHE_TAG_LO-`ICACHE_INDEX_LO];
		even_index = req_even_pair[`ICACHE_INDEX_HI-`ICACHE_INDEX_LO:0];
		even_tag = req_even_pair[31-`ICACHE_INDEX_LO:`ICACHE_TAG_LO-`ICACHE_INDEX_LO];
	end

	// Data banks read the way the tag compare found in stage 1
	// A missing line reads some way, which the hit flag then marks as unusable
	always_comb begin
		even_way = even_hit_way;
		odd_way = odd_hit_way;
	end

	// ====================
	// Stage 1
	// ====================

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		s1_ip <= fetch_req.ip;
	end

	// ====================
	// Stage 2
	// ====================

	always_ff @(posedge clk) begin
		if (reset) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	// Both lines are kept in bank order, the window order is settled afterwards
	always_ff @(posedge clk) begin
		s2_ip <= s1_ip;
		s2_even_hit <= even_hit;
		s2_odd_hit <= odd_hit;
		s2_even_line <= even_line;
		s2_odd_line <= odd_line;
	end

	// A window only hits when both of its lines were present
	always_comb s2_hit = s2_even_hit && s2_odd_hit;

	always_comb begin
		fetch_rsp.valid = s2_valid;
		fetch_rsp.hit = s2_hit;
		fetch_rsp.ip = s2_ip;
		// The line holding ip goes low, the next line high
		if (s2_ip[`ICACHE_BANK_BIT]) begin
			fetch_rsp.window = {s2_even_line, s2_odd_line};
		end else begin
			fetch_rsp.window = {s2_odd_line, s2_even_line};
		end
	end

	// Line addresses for the refill, rebuilt from the stage-2 ip
	always_comb begin
		s2_even_pair = s2_ip[31:`ICACHE_INDEX_LO] + s2_ip[`ICACHE_BANK_BIT];
		miss.valid = s2_valid && !s2_hit;
		miss.need_even = !s2_even_hit;
		miss.need_odd = !s2_odd_hit;
		miss.even_addr = {s2_even_pair, 1'b0, {`ICACHE_BANK_BIT{1'b0}}};
		miss.odd_addr = {s2_ip[31:`ICACHE_INDEX_LO], 1'b1, {`ICACHE_BANK_BIT{1'b0}}};
	end

endmodule

//--- source/icache_refill_counter.sv
// Refill beat counter and round-robin victim way counters of the two banks
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_refill_counter import icache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic beat_clear,
	input logic beat_step,
	output beat_t beat,
	output logic last_beat,
	input logic victim_step_even,
	input logic victim_step_odd,
	output way_t victim_even,
	output way_t victim_odd
);

	// ====================
	// Beat count
	// ====================

	// last_beat is kept as its own flop so the FSM sees it without a compare
	always_ff @(posedge clk) begin
		if (reset || beat_clear) begin
			beat <= '0;
			last_beat <= 1'b0;
		end else if (beat_step) begin
			beat <= beat + 1'b1;
			last_beat <= beat == beat_t'(`ICACHE_LINE_WORDS - 2);
		end
	end

	// ====================
	// Victim ways
	// ====================

	// Each bank replaces its ways in turn, wrapping from the last way to way 0
	// invalidate_all leaves these alone
	always_ff @(posedge clk) begin
		if (reset) begin
			victim_even <= '0;
			victim_odd <= '0;
		end else begin
			if (victim_step_even) begin
				victim_even <= victim_even + 1'b1;
			end
			if (victim_step_odd) begin
				victim_odd <= victim_odd + 1'b1;
			end
		end
	end

endmodule

//--- source/icache_refill_fsm.sv
// Refill state machine that reads missing lines over APB and writes them into the banks
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_refill_fsm import icache_pkg::*; (
	input logic clk,
	input logic reset,
	input miss_t miss,
	output apb_req_t apb_req,
	input apb_rsp_t apb_rsp,
	input beat_t beat,
	input logic last_beat,
	input way_t victim_even,
	input way_t victim_odd,
	output logic beat_clear,
	output logic beat_step,
	output logic victim_step_even,
	output logic victim_step_odd,
	output bank_wr_t wr,
	output logic busy,
	output logic refill_error
);

	refill_state_t state;
	refill_state_t state_next;

	// Line being filled and the one queued behind it
	addr_t cur_addr;
	addr_t next_addr;
	logic next_pending;

	logic take_miss;
	logic ip_in_even;
	logic cur_odd;
	logic word_ok;

	// Misses are only taken while idle, anything else is dropped and retried
	always_comb take_miss = (state == st_idle) && miss.valid;

	// Even and odd lines in the same pair means ip sits in the even line
	always_comb begin
		ip_in_even = miss.even_addr[31:`ICACHE_INDEX_LO] == miss.odd_addr[31:`ICACHE_INDEX_LO];
	end

	always_comb cur_odd = cur_addr[`ICACHE_BANK_BIT];

	// A good word ends the access phase without a slave error
	always_comb begin
		word_ok = (state == st_access) && apb_rsp.pready && !apb_rsp.pslverr;
	end

	// ====================
	// State sequencing
	// ====================

	always_comb begin
		state_next = state;
		unique case (state)
			st_idle: if (miss.valid) state_next = st_setup;
			st_setup: state_next = st_access;
			st_access: begin
				if (apb_rsp.pready) begin
					if (apb_rsp.pslverr) begin
						state_next = st_error;
					end else if (last_beat) begin
						state_next = st_commit;
					end else begin
						state_next = st_setup;
					end
				end
			end
			st_commit: state_next = next_pending ? st_setup : st_idle;
			st_error: state_next = st_idle;
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			next_pending <= 1'b0;
		end else begin
			state <= state_next;
			if (take_miss) begin
				next_pending <= miss.need_even && miss.need_odd;
			end else if (state == st_commit || state == st_error) begin
				// Second line taken up, or skipped after an error
				next_pending <= 1'b0;
			end
		end
	end

	// The line holding ip is filled first
	always_ff @(posedge clk) begin
		if (take_miss) begin
			if (miss.need_even && miss.need_odd) begin
				cur_addr <= ip_in_even ? miss.even_addr : miss.odd_addr;
				next_addr <= ip_in_even ? miss.odd_addr : miss.even_addr;
			end else begin
				cur_addr <= miss.need_even ? miss.even_addr : miss.odd_addr;
				next_addr <= miss.odd_addr;
			end
		end else if (state == st_commit && next_pending) begin
			cur_addr <= next_addr;
		end
	end

	// ====================
	// Outputs
	// ====================

	// Word addresses climb through the line, reads only
	always_comb begin
		apb_req.psel = (state == st_setup) || (state == st_access);
		apb_req.penable = state == st_access;
		apb_req.paddr = {cur_addr[31:`ICACHE_BANK_BIT], beat, 2'b00};
		apb_req.pwrite = 1'b0;
	end

	always_comb begin
		beat_clear = take_miss || (state == st_commit && next_pending);
		beat_step = word_ok;
		// The victim moves on only once the line is valid
		victim_step_even = (state == st_commit) && !cur_odd;
		victim_step_odd = (state == st_commit) && cur_odd;
	end

	// Each returned word goes straight into the victim way of its bank
	always_comb begin
		wr.we_even = word_ok && !cur_odd;
		wr.we_odd = word_ok && cur_odd;
		wr.index = cur_addr[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
		wr.way = cur_odd ? victim_odd : victim_even;
		wr.beat = beat;
		wr.word = apb_rsp.prdata;
		wr.tag = cur_addr[31:`ICACHE_TAG_LO];
		wr.commit = last_beat;
	end

	always_comb busy = state != st_idle;
	always_comb refill_error = state == st_error;

endmodule

//--- source/icache_top.sv
// Instruction cache top level joining lookup, both banks, refill machine and counters
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
	input logic clk,
	input logic reset,
	input fetch_req_t fetch_req,
	output logic fetch_ready,
	output fetch_rsp_t fetch_rsp,
	output apb_req_t apb_req,
	input apb_rsp_t apb_rsp,
	input logic invalidate_all,
	output logic refill_error
);

	set_index_t even_index;
	set_index_t odd_index;
	tag_t even_tag;
	tag_t odd_tag;
	logic even_hit;
	logic odd_hit;
	way_t even_hit_way;
	way_t odd_hit_way;
	way_t even_way;
	way_t odd_way;
	line_t even_line;
	line_t odd_line;

	miss_t miss;
	bank_wr_t bank_wr;
	beat_t beat;
	logic last_beat;
	way_t victim_even;
	way_t victim_odd;
	logic beat_clear;
	logic beat_step;
	logic victim_step_even;
	logic victim_step_odd;
	logic busy;

	// New fetches wait while a refill is running
	assign fetch_ready = !busy;

	icache_lookup i_lookup (
		.clk(clk), .reset(reset),
		.fetch_req(fetch_req), .fetch_ready(fetch_ready), .fetch_rsp(fetch_rsp),
		.miss(miss),
		.even_index(even_index), .odd_index(odd_index),
		.even_tag(even_tag), .odd_tag(odd_tag),
		.even_hit(even_hit), .odd_hit(odd_hit),
		.even_way(even_way), .odd_way(odd_way),
		.even_hit_way(even_hit_way), .odd_hit_way(odd_hit_way),
		.even_line(even_line), .odd_line(odd_line)
	);

	// ====================
	// Banks
	// ====================

	// bank_sel ties each bank to its own write enable
	icache_tag_bank i_even_tags (
		.clk(clk), .reset(reset), .rd_index(even_index), .rd_tag(even_tag),
		.wr(bank_wr), .bank_sel(1'b0), .invalidate_all(invalidate_all),
		.hit(even_hit), .hit_way(even_hit_way)
	);

	icache_tag_bank i_odd_tags (
		.clk(clk), .reset(reset), .rd_index(odd_index), .rd_tag(odd_tag),
		.wr(bank_wr), .bank_sel(1'b1), .invalidate_all(invalidate_all),
		.hit(odd_hit), .hit_way(odd_hit_way)
	);

	icache_data_bank i_even_data (
		.clk(clk), .rd_index(even_index), .rd_way(even_way),
		.wr(bank_wr), .bank_sel(1'b0), .rd_line(even_line)
	);

	icache_data_bank i_odd_data (
		.clk(clk), .rd_index(odd_index), .rd_way(odd_way),
		.wr(bank_wr), .bank_sel(1'b1), .rd_line(odd_line)
	);

	// ====================
	// Refill
	// ====================

	icache_refill_fsm i_refill_fsm (
		.clk(clk), .reset(reset), .miss(miss),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.beat(beat), .last_beat(last_beat),
		.victim_even(victim_even), .victim_odd(victim_odd),
		.beat_clear(beat_clear), .beat_step(beat_step),
		.victim_step_even(victim_step_even), .victim_step_odd(victim_step_odd),
		.wr(bank_wr), .busy(busy), .refill_error(refill_error)
	);

	icache_refill_counter i_refill_counter (
		.clk(clk), .reset(reset),
		.beat_clear(beat_clear), .beat_step(beat_step),
		.beat(beat), .last_beat(last_beat),
		.victim_step_even(victim_step_even), .victim_step_odd(victim_step_odd),
		.victim_even(victim_even), .victim_odd(victim_odd)
	);

endmodule

//--- bench/icache_tb.sv
// Directed testbench for the instruction cache with an APB memory and a model of its contents
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tb import icache_pkg::*; ();

	// Worst-case refill is two lines of eight beats with a setup, an access and all waits on each
	localparam int max_wait = 3;
	localparam int clk_period = 20;
	localparam int refill_cycles = 2 * `ICACHE_LINE_WORDS * (max_wait + 2) + 8;
	localparam int test_count = 6;
	localparam int fetches_per_test = 12;
	localparam int watchdog_cycles = test_count * fetches_per_test * (refill_cycles + 8);

	logic clk;
	logic reset;
	fetch_req_t fetch_req;
	logic fetch_ready;
	fetch_rsp_t fetch_rsp;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic invalidate_all;
	logic refill_error;

	int error_count = 0;
	int tests_run = 0;
	int error_pulses = 0;
	int wait_left = 0;
	logic [31:0] wait_rng = 32'hf087;
	logic [31:0] addr_rng = 32'hf087;

	// Slave error injection for one chosen word address
	logic err_enable;
	addr_t err_addr;

	// Reference model of both banks indexed by bank, set and way
	tag_t m_tag [2][`ICACHE_SETS][`ICACHE_WAYS];
	logic m_valid [2][`ICACHE_SETS][`ICACHE_WAYS];
	way_t m_victim [2];

	icache_top i_dut (
		.clk(clk), .reset(reset),
		.fetch_req(fetch_req), .fetch_ready(fetch_ready), .fetch_rsp(fetch_rsp),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.invalidate_all(invalidate_all), .refill_error(refill_error)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Every memory word holds its own byte address XOR a fixed pattern
	function automatic line_t line_words(input addr_t line_addr);
		line_t l;
		for (int b = 0; b < `ICACHE_LINE_WORDS; b++) begin
			l[32*b +: 32] = (line_addr + 32'(4 * b)) ^ 32'h5a5a_0000;
		end
		return l;
	endfunction

	function automatic logic line_present(input addr_t a);
		logic found;
		logic bank;
		set_index_t set;
		found = 1'b0;
		bank = a[`ICACHE_BANK_BIT];
		set = a[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (m_valid[bank][set][w] && m_tag[bank][set][w] == a[31:`ICACHE_TAG_LO]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic report_mismatch(input string name, input logic [511:0] exp,
			input logic [511:0] got);
		error_count++;
		$display("** Error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("Failure at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int start);
		tests_run++;
		$display("%s finished with %0d errors", name, error_count - start);
	endtask

	task automatic clear_model_valid();
		for (int b = 0; b < 2; b++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				for (int w = 0; w < `ICACHE_WAYS; w++) begin
					m_valid[b][s][w] = 1'b0;
				end
			end
		end
	endtask

	// Right after reset nothing is in flight and no refill is running
	task automatic check_reset_state();
		if (fetch_ready !== 1'b1) begin
			report_mismatch("fetch_ready", 1'b1, fetch_ready);
		end
		if (fetch_rsp.valid !== 1'b0) begin
			report_mismatch("fetch_rsp.valid", 1'b0, fetch_rsp.valid);
		end
		if (refill_error !== 1'b0) begin
			report_mismatch("refill_error", 1'b0, refill_error);
		end
		if (apb_req.psel !== 1'b0) begin
			report_mismatch("apb_req.psel", 1'b0, apb_req.psel);
		end
		if (apb_req.penable !== 1'b0) begin
			report_mismatch("apb_req.penable", 1'b0, apb_req.penable);
		end
	endtask

	// Fills the missing lines in order with the line of ip first and stops at a slave error
	task automatic model_refill(input addr_t ip, output logic exp_error);
		addr_t lines [2];
		addr_t a;
		logic bank;
		set_index_t set;
		int i;
		lines[0] = {ip[31:`ICACHE_BANK_BIT], 5'b0};
		lines[1] = lines[0] + 32'd32;
		exp_error = 1'b0;
		for (i = 0; i < 2; i++) begin
			a = lines[i];
			if (!exp_error && !line_present(a)) begin
				if (err_enable && err_addr[31:`ICACHE_BANK_BIT] == a[31:`ICACHE_BANK_BIT]) begin
					exp_error = 1'b1;
				end else begin
					bank = a[`ICACHE_BANK_BIT];
					set = a[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
					m_tag[bank][set][m_victim[bank]] = a[31:`ICACHE_TAG_LO];
					m_valid[bank][set][m_victim[bank]] = 1'b1;
					m_victim[bank] = m_victim[bank] + 1'b1;
				end
			end
		end
	endtask

	task automatic wait_for_ready();
		int n;
		n = 0;
		while (!fetch_ready && n < 2 * refill_cycles) begin
			@(negedge clk);
			n++;
		end
		if (!fetch_ready) begin
			report_failure("fetch_ready never came back after a refill");
		end
	endtask

	task automatic check_response(input addr_t ip, input logic exp_hit);
		addr_t line_lo;
		window_t exp_window;
		line_lo = {ip[31:`ICACHE_BANK_BIT], 5'b0};
		// The line holding ip sits in the low half of the window
		exp_window = {line_words(line_lo + 32'd32), line_words(line_lo)};
		if (fetch_rsp.valid !== 1'b1) begin
			report_mismatch("fetch_rsp.valid", 1'b1, fetch_rsp.valid);
		end
		if (fetch_rsp.ip !== ip) begin
			report_mismatch("fetch_rsp.ip", ip, fetch_rsp.ip);
		end
		if (fetch_rsp.hit !== exp_hit) begin
			report_mismatch("fetch_rsp.hit", exp_hit, fetch_rsp.hit);
		end
		if (exp_hit && fetch_rsp.hit === 1'b1 && fetch_rsp.window !== exp_window) begin
			report_mismatch("fetch_rsp.window", exp_window, fetch_rsp.window);
		end
	endtask

	// One fetch is checked against the model and on a miss the whole refill is awaited
	task automatic fetch_and_check(input addr_t ip);
		addr_t line_lo;
		logic exp_hit;
		logic exp_error;
		int latency;
		int pulses_before;
		line_lo = {ip[31:`ICACHE_BANK_BIT], 5'b0};
		exp_hit = line_present(line_lo) && line_present(line_lo + 32'd32);
		wait_for_ready();
		fetch_req.valid = 1'b1;
		fetch_req.ip = ip;
		@(negedge clk);
		fetch_req.valid = 1'b0;
		latency = 1;
		while (!fetch_rsp.valid && latency < 8) begin
			@(negedge clk);
			latency++;
		end
		if (!fetch_rsp.valid) begin
			report_failure($sformatf("no response to the fetch of %h", ip));
			return;
		end
		if (latency != 2) begin
			report_mismatch("response latency", 2, latency);
		end
		check_response(ip, exp_hit);
		if (fetch_rsp.hit !== 1'b1) begin
			pulses_before = error_pulses;
			@(negedge clk);
			if (fetch_ready) begin
				report_failure("fetch_ready stayed high after a miss");
			end
			wait_for_ready();
			model_refill(ip, exp_error);
			if (error_pulses - pulses_before != int'(exp_error)) begin
				report_mismatch("refill_error pulses", exp_error, error_pulses - pulses_before);
			end
		end
	endtask

	// ====================
	// APB memory
	// ====================

	// A random number of wait states is picked in each setup phase
	always @(negedge clk) begin
		if (apb_req.psel && apb_req.pwrite) begin
			report_failure("APB write seen during a refill");
		end
		if (apb_req.psel && !apb_req.penable) begin
			wait_left = wait_rng % (max_wait + 1);
			wait_rng = xorshift32(wait_rng);
			apb_rsp = '0;
		end else if (apb_req.psel && apb_req.penable) begin
			if (wait_left == 0) begin
				apb_rsp.pready = 1'b1;
				apb_rsp.prdata = apb_req.paddr ^ 32'h5a5a_0000;
				apb_rsp.pslverr = err_enable && apb_req.paddr == err_addr;
			end else begin
				apb_rsp.pready = 1'b0;
				wait_left--;
			end
		end else begin
			apb_rsp = '0;
		end
	end

	always @(negedge clk) begin
		if (!reset && refill_error) begin
			error_pulses = error_pulses + 1;
		end
	end

	// ====================
	// Tests
	// ====================

	task automatic test_first_fetch();
		int start;
		start = error_count;
		check_reset_state();
		fetch_and_check(32'h0000_1004);
		fetch_and_check(32'h0000_1004);
		end_test("first fetch", start);
	endtask

	// An odd line in set 15 puts the next line in even set 0 of the following tag
	task automatic test_wrap_window();
		int start;
		start = error_count;
		fetch_and_check(32'h0000_27e8);
		fetch_and_check(32'h0000_27e8);
		end_test("wrapping window", start);
	endtask

	task automatic test_back_to_back();
		addr_t bases [3];
		addr_t reqs [$];
		logic hits [$];
		addr_t ip;
		addr_t line_lo;
		int start;
		int k;
		start = error_count;
		fetch_and_check(32'h0000_3044);
		fetch_and_check(32'h0000_3044);
		bases[0] = 32'h0000_1000;
		bases[1] = 32'h0000_27e0;
		bases[2] = 32'h0000_3040;
		for (k = 0; k < 8; k++) begin
			addr_rng = xorshift32(addr_rng);
			ip = bases[addr_rng % 3] | {27'd0, addr_rng[4:2], 2'b00};
			line_lo = {ip[31:5], 5'b0};
			reqs.push_back(ip);
			hits.push_back(line_present(line_lo) && line_present(line_lo + 32'd32));
		end
		wait_for_ready();
		// The last single fetch still shows its response until the next falling edge
		@(negedge clk);
		// Each response shows up two negedges after its request was driven
		for (k = 0; k < reqs.size() + 2; k++) begin
			if (k >= 2) begin
				check_response(reqs[k-2], hits[k-2]);
			end else if (fetch_rsp.valid !== 1'b0) begin
				report_failure("response seen before the burst could produce one");
			end
			if (k < reqs.size()) begin
				fetch_req.valid = 1'b1;
				fetch_req.ip = reqs[k];
			end else begin
				fetch_req.valid = 1'b0;
			end
			@(negedge clk);
		end
		end_test("back-to-back hits", start);
	endtask

	// Five tags fill set 5 and are refetched newest first so only the oldest has been evicted
	task automatic test_round_robin();
		int start;
		int t;
		start = error_count;
		for (t = 0; t < 5; t++) begin
			fetch_and_check({22'(20 + t), 4'd5, 6'h04});
		end
		for (t = 4; t >= 0; t--) begin
			fetch_and_check({22'(20 + t), 4'd5, 6'h04});
		end
		end_test("round-robin eviction", start);
	endtask

	task automatic test_slave_error();
		int start;
		start = error_count;
		err_addr = 32'h0000_9108;
		err_enable = 1'b1;
		fetch_and_check(32'h0000_9104);
		err_enable = 1'b0;
		fetch_and_check(32'h0000_9104);
		fetch_and_check(32'h0000_9104);
		end_test("slave error", start);
	endtask

	task automatic test_invalidate();
		int start;
		start = error_count;
		invalidate_all = 1'b1;
		@(negedge clk);
		invalidate_all = 1'b0;
		clear_model_valid();
		fetch_and_check(32'h0000_1004);
		fetch_and_check(32'h0000_1004);
		fetch_and_check(32'h0000_27e8);
		end_test("invalidate all", start);
	endtask

	// ====================
	// Run
	// ====================

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, the run hung", watchdog_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		fetch_req = '0;
		apb_rsp = '0;
		invalidate_all = 1'b0;
		err_enable = 1'b0;
		err_addr = '0;
		clear_model_valid();
		m_victim[0] = '0;
		m_victim[1] = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_first_fetch();
		test_wrap_window();
		test_back_to_back();
		test_round_robin();
		test_slave_error();
		test_invalidate();
		$display("%0d tests run, %0d errors", tests_run, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- icache_top.f
+incdir+source
source/icache_pkg.sv
source/icache_tag_bank.sv
source/icache_data_bank.sv
source/icache_lookup.sv
source/icache_refill_counter.sv
source/icache_refill_fsm.sv
source/icache_top.sv
bench/icache_tb.sv
